// File: bench/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// ==================================================
// random source and memory data
// ==================================================

// galois lfsr, shift right, taps for x^32+x^30+x^26+x^25+1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  if (state[0])
    return (state >> 1) ^ 32'hA300_0000;
  return state >> 1;
endfunction

// beat contents follow the byte address of the beat
function automatic logic [BEAT_W-1:0] beat_pattern(input logic [31:0] addr, input int idx);
  logic [31:0] beat_addr;
  beat_addr = addr + 32'(idx) * 32'(BYTES_PER_BEAT);
  return {beat_addr ^ 32'hC3A5_0F96, ~beat_addr};
endfunction

// ==================================================
// memory responder
// ==================================================
// one beat per strobe, 0 to 3 idle cycles before each beat
task automatic send_beats(input logic [31:0] addr, input int beats);
  logic [1:0] gap;
  for (int i = 0; i < beats; i++) begin
    gap_lfsr = lfsr_step(gap_lfsr);
    gap[0]   = gap_lfsr[0];
    gap_lfsr = lfsr_step(gap_lfsr);
    gap[1]   = gap_lfsr[0];
    repeat (gap) begin
      @(posedge clk);
      mem_beat.valid <= 1'b0;
    end
    @(posedge clk);
    mem_beat.valid <= 1'b1;
    mem_beat.data  <= beat_pattern(addr, i);
  end
  @(posedge clk);
  mem_beat.valid <= 1'b0;
endtask

`endif

// File: bench/tb_chip_rd_top.sv
`timescale 1ns/1ps
module tb_chip_rd_top
  import mem_map_pkg::*;
  import chip_cmd_pkg::*;
();

  typedef struct packed {
    logic [31:0]        cmd;
    logic [3:0]         op;     // opcode expected on which_write
    logic [ADDR_W-1:0]  addr;
    logic [BEATS_W-1:0] beats;  // 0 means no request at all
  } cmd_entry_t;

  localparam int NUM_CMDS = 15;

  // ==================================================
  // command table
  // ==================================================
  cmd_entry_t cmd_table [NUM_CMDS] = '{
    '{32'h1000_0000, 4'h1, 32'h0804_0000, 10'd6},
    '{32'h2000_0000, 4'h2, 32'h0800_0000, 10'd12},
    '{32'h2000_00a5, 4'h2, 32'h0800_0060, 10'd12},  // next act block
    '{32'h3000_0000, 4'h3, 32'h0801_0000, 10'd6},
    '{32'h4000_0000, 4'h4, 32'h0802_0000, 10'd24},
    '{32'h5000_0000, 4'h5, 32'h0803_0000, 10'd6},
    '{32'h4000_1234, 4'h4, 32'h0802_00c0, 10'd24},
    '{32'h2000_0000, 4'h2, 32'h0800_00c0, 10'd12},
    '{32'h9000_0000, 4'h9, 32'h0000_0000, 10'd0},   // unknown opcode
    '{32'h5000_0000, 4'h5, 32'h0803_0030, 10'd6},
    '{32'h1800_0000, 4'h1, 32'h0804_0030, 10'd6},   // cfg with restart
    '{32'h4000_0000, 4'h4, 32'h0802_0000, 10'd24},
    '{32'h5000_0000, 4'h5, 32'h0803_0000, 10'd6},
    '{32'h4800_0000, 4'h4, 32'h0802_0000, 10'd24},  // wei with restart
    '{32'h4000_0000, 4'h4, 32'h0802_00c0, 10'd24}
  };

  logic        clk = 1'b0;
  logic        reset;
  logic        config_req;
  logic [31:0] chip_cmd;
  logic        full;
  mem_beat_t   mem_beat;
  mem_rd_req_t mem_req;
  chip_out_t   chip_out;
  opcode_t     which_write;

  logic [31:0] gap_lfsr  = 32'd32;
  logic [31:0] full_lfsr = 32'd32;
  logic [31:0] cur_addr;
  int          cur_words;
  int          got_words;
  int          req_seen;
  int          reqs_expected;
  logic        full_prev;

  `include "tb_mem_model.svh"

  chip_rd_top #(.BEAT_FIFO_LOG2(6), .WORD_FIFO_LOG2(5)) UUT (
    .clk(clk), .reset(reset),
    .config_req(config_req), .chip_cmd(chip_cmd), .full(full),
    .mem_beat(mem_beat), .mem_req(mem_req),
    .chip_out(chip_out), .which_write(which_write)
  );

  always #20 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  // word k of a transfer, three beats give two words, low bits first
  function automatic logic [WORD_W-1:0] packed_word(input logic [31:0] addr, input int k);
    logic [3*BEAT_W-1:0] triple;
    int                  first;
    first  = (k / 2) * 3;
    triple = {beat_pattern(addr, first + 2), beat_pattern(addr, first + 1),
              beat_pattern(addr, first)};
    if (k % 2 == 0)
      return triple[WORD_W-1:0];
    else
      return triple[2*WORD_W-1:WORD_W];
  endfunction

  function automatic int timeout_cycles();
    int total;
    total = 100;  // reset and tail
    foreach (cmd_table[i]) total += 64 + 16 * int'(cmd_table[i].beats);
    return total;
  endfunction

  // ==================================================
  // chip model
  // ==================================================
  always @(posedge clk) begin
    full_lfsr = lfsr_step(full_lfsr);
    full <= full_lfsr[0];  // random stall
  end

  always @(negedge clk) begin
    if (reset) begin
      if (mem_req.valid) req_seen++;
      if (!chip_out.cs_n) begin
        assert (!full_prev) else stop_on_error("word delivered after a full cycle");
        assert (chip_out.oe) else stop_on_error("word delivered with oe low");
        assert (got_words < cur_words) else stop_on_error("more words than expected");
        assert (chip_out.data == packed_word(cur_addr, got_words))
          else stop_on_error($sformatf("word %0d is %h, expected %h", got_words,
                                       chip_out.data, packed_word(cur_addr, got_words)));
        got_words++;
      end
      full_prev = full;
    end
  end

  task automatic run_command(input int idx);
    cmd_entry_t e;
    e = cmd_table[idx];
    cur_addr  = e.addr;
    cur_words = int'(e.beats) * 2 / 3;
    got_words = 0;
    if (e.beats != 0) reqs_expected++;
    @(posedge clk);
    chip_cmd   <= e.cmd;
    config_req <= 1'b1;
    do @(negedge clk); while (!chip_out.oe);  // decode done, request out
    assert (4'(which_write) == e.op)
      else stop_on_error($sformatf("which_write %h, expected %h", which_write, e.op));
    if (e.beats != 0) begin
      assert (mem_req.valid) else stop_on_error("no memory request with oe rising");
      assert (mem_req.addr == e.addr)
        else stop_on_error($sformatf("cmd %0d address %h, expected %h", idx,
                                     mem_req.addr, e.addr));
      assert (mem_req.beats == e.beats)
        else stop_on_error($sformatf("cmd %0d beats %0d, expected %0d", idx,
                                     mem_req.beats, e.beats));
    end
    @(posedge clk);
    config_req <= 1'b0;
    if (e.beats != 0) send_beats(e.addr, int'(e.beats));
    do @(negedge clk); while (chip_out.oe);   // end of transfer
    assert (got_words == cur_words)
      else stop_on_error($sformatf("cmd %0d gave %0d words, expected %0d", idx,
                                   got_words, cur_words));
    assert (req_seen == reqs_expected)
      else stop_on_error($sformatf("%0d requests seen, expected %0d", req_seen,
                                   reqs_expected));
    repeat (6) @(posedge clk);  // let RD_STILL run out
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    reset         = 1'b0;
    config_req    = 1'b0;
    chip_cmd      = '0;
    full          = 1'b0;
    mem_beat      = '0;
    full_prev     = 1'b0;
    cur_addr      = '0;
    cur_words     = 0;
    got_words     = 0;
    req_seen      = 0;
    reqs_expected = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    assert (chip_out.cs_n && !chip_out.oe && !mem_req.valid && 4'(which_write) == 4'h0)
      else stop_on_error("outputs not at their reset values");
    for (int i = 0; i < NUM_CMDS; i++) run_command(i);
    $display("*** PASSED ***");
    $finish;
  end

  initial begin : watchdog
    int limit;
    int cycles;
    limit  = timeout_cycles();
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the command table did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped by watchdog");
  end

endmodule

// File: chip_rd_top.f
+incdir+bench
common/mem_map_pkg.sv
common/chip_cmd_pkg.sv
hdl/fifo_fwft.sv
read_path/beat_repacker.sv
read_path/read_path.sv
hdl/cmd_decoder.sv
hdl/rd_sequencer.sv
hdl/chip_rd_top.sv
bench/tb_chip_rd_top.sv

// File: common/chip_cmd_pkg.sv
package chip_cmd_pkg;

  import mem_map_pkg::*;

  // ==================================================
  // command word
  // ==================================================
  typedef enum logic [3:0] {
    CFG    = 4'h1,
    ACT    = 4'h2,
    FLGACT = 4'h3,
    WEI    = 4'h4,
    FLGWEI = 4'h5
  } opcode_t;

  localparam int OP_MSB      = 31;
  localparam int OP_LSB      = 28;
  localparam int RESTART_BIT = 27;  // restart weight blocks from 0

  // read sequencer states
  typedef enum logic [2:0] {IDLE, CONFIG, WAIT, RD_DATA, RD_STILL} seq_state_t;

  // ==================================================
  // bus structs
  // ==================================================
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [BEATS_W-1:0] beats;
  } mem_rd_req_t;

  typedef struct packed {
    logic              valid;
    logic [BEAT_W-1:0] data;
  } mem_beat_t;

  typedef struct packed {
    logic              cs_n;   // low while data holds a word
    logic              oe;
    logic [WORD_W-1:0] data;
  } chip_out_t;

endpackage

// File: common/mem_map_pkg.sv
package mem_map_pkg;

  // ==================================================
  // bus widths
  // ==================================================
  localparam int ADDR_W  = 32;  // memory byte address
  localparam int BEAT_W  = 64;  // one memory beat
  localparam int WORD_W  = 96;  // one chip word
  localparam int BEATS_W = 10;  // beat / word counts

  localparam int BYTES_PER_BEAT = BEAT_W / 8;

  // ==================================================
  // region base addresses
  // ==================================================
  localparam logic [ADDR_W-1:0] CFG_BASE      = 32'h0804_0000;
  localparam logic [ADDR_W-1:0] ACT_BASE      = 32'h0800_0000;
  localparam logic [ADDR_W-1:0] ACT_FLAG_BASE = 32'h0801_0000;
  localparam logic [ADDR_W-1:0] WEI_BASE      = 32'h0802_0000;
  localparam logic [ADDR_W-1:0] WEI_FLAG_BASE = 32'h0803_0000;

  // ==================================================
  // block sizes in beats
  // ==================================================
  // three beats repack into two chip words, so every
  // block is a whole number of beat triples
  localparam int CFG_BEATS      = 6;
  localparam int ACT_BEATS      = 12;
  localparam int ACT_FLAG_BEATS = 6;
  localparam int WEI_BEATS      = 24;   // largest transfer
  localparam int WEI_FLAG_BEATS = 6;

endpackage

// File: hdl/chip_rd_top.sv
`timescale 1ns/1ps
module chip_rd_top
  import mem_map_pkg::*;
  import chip_cmd_pkg::*;
#(
  parameter int BEAT_FIFO_LOG2 = 6,
  parameter int WORD_FIFO_LOG2 = 5
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        config_req,   // async from chip
  input  logic [31:0] chip_cmd,
  input  logic        full,
  input  mem_beat_t   mem_beat,
  output mem_rd_req_t mem_req,
  output chip_out_t   chip_out,
  output opcode_t     which_write
);

  logic               decode_stb;
  logic [31:0]        cmd;
  logic [BEATS_W-1:0] expected_words;
  logic               word_valid;
  logic [WORD_W-1:0]  word_data;
  logic               word_pop;

  // ==================================================
  // command decode and memory request
  // ==================================================
  cmd_decoder u_decoder (
    .clk(clk), .reset(reset),
    .decode_stb(decode_stb), .cmd(cmd),
    .mem_req(mem_req), .expected_words(expected_words),
    .which_write(which_write)
  );

  // ==================================================
  // sequencing and chip stream
  // ==================================================
  rd_sequencer u_sequencer (
    .clk(clk), .reset(reset),
    .config_req(config_req), .cmd_in(chip_cmd), .full(full),
    .expected_words(expected_words),
    .word_valid(word_valid), .word_data(word_data), .word_pop(word_pop),
    .decode_stb(decode_stb), .cmd(cmd), .chip_out(chip_out)
  );

  read_path #(
    .BEAT_FIFO_LOG2(BEAT_FIFO_LOG2),
    .WORD_FIFO_LOG2(WORD_FIFO_LOG2)
  ) u_read_path (
    .clk(clk), .reset(reset),
    .mem_beat(mem_beat), .word_pop(word_pop),
    .word_valid(word_valid), .word_data(word_data)
  );

endmodule

// File: hdl/cmd_decoder.sv
`timescale 1ns/1ps
module cmd_decoder
  import mem_map_pkg::*;
  import chip_cmd_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               decode_stb,
  input  logic [31:0]        cmd,
  output mem_rd_req_t        mem_req,
  output logic [BEATS_W-1:0] expected_words,
  output opcode_t            which_write
);

  localparam int BLK_W = 16;  // block index per region

  opcode_t            op;
  logic               restart;
  logic [BLK_W-1:0]   cfg_cnt, act_cnt, aflg_cnt, wei_cnt, wflg_cnt;
  logic [BLK_W-1:0]   wei_idx, wflg_idx;
  logic [BLK_W-1:0]   sel_idx;
  logic [ADDR_W-1:0]  sel_base;
  logic [BEATS_W-1:0] sel_beats;
  logic [BEATS_W-1:0] sel_words;
  logic               sel_valid;

  assign op      = opcode_t'(cmd[OP_MSB:OP_LSB]);
  assign restart = cmd[RESTART_BIT];

  // restart applies before the weight index is used
  assign wei_idx  = restart ? '0 : wei_cnt;
  assign wflg_idx = restart ? '0 : wflg_cnt;

  // ==================================================
  // region select
  // ==================================================
  always_comb begin
    sel_valid = 1'b1;
    sel_base  = ACT_BASE;
    sel_idx   = '0;
    sel_beats = '0;
    sel_words = '0;
    case (op)
      CFG: begin
        sel_base  = CFG_BASE;
        sel_idx   = cfg_cnt;
        sel_beats = BEATS_W'(CFG_BEATS);
        sel_words = BEATS_W'(CFG_BEATS * 2 / 3);
      end
      ACT: begin
        sel_base  = ACT_BASE;
        sel_idx   = act_cnt;
        sel_beats = BEATS_W'(ACT_BEATS);
        sel_words = BEATS_W'(ACT_BEATS * 2 / 3);
      end
      FLGACT: begin
        sel_base  = ACT_FLAG_BASE;
        sel_idx   = aflg_cnt;
        sel_beats = BEATS_W'(ACT_FLAG_BEATS);
        sel_words = BEATS_W'(ACT_FLAG_BEATS * 2 / 3);
      end
      WEI: begin
        sel_base  = WEI_BASE;
        sel_idx   = wei_idx;
        sel_beats = BEATS_W'(WEI_BEATS);
        sel_words = BEATS_W'(WEI_BEATS * 2 / 3);
      end
      FLGWEI: begin
        sel_base  = WEI_FLAG_BASE;
        sel_idx   = wflg_idx;
        sel_beats = BEATS_W'(WEI_FLAG_BEATS);
        sel_words = BEATS_W'(WEI_FLAG_BEATS * 2 / 3);
      end
      default: sel_valid = 1'b0;  // unknown opcode, no request
    endcase
  end

  // ==================================================
  // request register and block counters
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      mem_req        <= '0;
      expected_words <= '0;
      which_write    <= opcode_t'(4'h0);
      cfg_cnt        <= '0;
      act_cnt        <= '0;
      aflg_cnt       <= '0;
      wei_cnt        <= '0;
      wflg_cnt       <= '0;
    end else if (decode_stb) begin
      mem_req.valid  <= sel_valid;
      mem_req.addr   <= sel_base + ADDR_W'(sel_idx) * ADDR_W'(sel_beats) * BYTES_PER_BEAT;
      mem_req.beats  <= sel_beats;
      expected_words <= sel_words;
      which_write    <= op;
      if (restart) begin
        wei_cnt  <= '0;
        wflg_cnt <= '0;
      end
      case (op)
        CFG:     cfg_cnt  <= cfg_cnt + 1'b1;
        ACT:     act_cnt  <= act_cnt + 1'b1;
        FLGACT:  aflg_cnt <= aflg_cnt + 1'b1;
        WEI:     wei_cnt  <= wei_idx + 1'b1;
        FLGWEI:  wflg_cnt <= wflg_idx + 1'b1;
        default: ;
      endcase
    end else begin
      mem_req.valid <= 1'b0;  // single cycle strobe
    end
  end

endmodule

// File: hdl/fifo_fwft.sv
`timescale 1ns/1ps
module fifo_fwft #(
  parameter int DATA_W     = 64,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  logic [DATA_W-1:0] data_in,
  output logic              full,
  input  logic              pop,
  output logic              empty,
  output logic [DATA_W-1:0] data_out
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [DATA_W-1:0]   mem [DEPTH];
  logic [DEPTH_LOG2:0] wr_ptr;   // extra msb tells full from empty
  logic [DEPTH_LOG2:0] rd_ptr;
  logic                do_push;
  logic                do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                 (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

  assign data_out = mem[rd_ptr[DEPTH_LOG2-1:0]];  // head word, no pop latency

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr[DEPTH_LOG2-1:0]] <= data_in;
  end

endmodule

// File: hdl/rd_sequencer.sv
`timescale 1ns/1ps
module rd_sequencer
  import mem_map_pkg::*;
  import chip_cmd_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               config_req,
  input  logic [31:0]        cmd_in,
  input  logic               full,
  input  logic [BEATS_W-1:0] expected_words,
  input  logic               word_valid,
  input  logic [WORD_W-1:0]  word_data,
  output logic               word_pop,
  output logic               decode_stb,
  output logic [31:0]        cmd,
  output chip_out_t          chip_out
);

  seq_state_t         state, next_state;
  logic [1:0]         req_sync;      // two flop synchroniser
  logic               req_d;         // for edge detect
  logic               req_rise;
  logic [BEATS_W-1:0] word_cnt;      // words popped this transfer
  logic [1:0]         still_cnt;
  logic               words_done;

  // ==================================================
  // config_req synchroniser
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      req_sync <= '0;
      req_d    <= 1'b0;
    end else begin
      req_sync <= {req_sync[0], config_req};
      req_d    <= req_sync[1];
    end
  end

  assign req_rise = req_sync[1] && !req_d;

  // ==================================================
  // transfer FSM
  // ==================================================
  assign words_done = (word_cnt == expected_words);
  assign decode_stb = (state == WAIT);
  assign word_pop   = (state == RD_DATA) && word_valid && !full && !words_done;

  always_comb begin
    next_state = state;
    case (state)
      IDLE:     if (req_rise) next_state = CONFIG;
      CONFIG:   next_state = WAIT;
      WAIT:     next_state = RD_DATA;
      RD_DATA:  if (words_done) next_state = RD_STILL;
      RD_STILL: if (still_cnt == 2'd2) next_state = IDLE;
      default:  next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state     <= IDLE;
      cmd       <= '0;
      word_cnt  <= '0;
      still_cnt <= '0;
    end else begin
      state <= next_state;
      if (state == CONFIG) cmd <= cmd_in;  // command sampled here
      if (state == WAIT) word_cnt <= '0;
      else if (word_pop) word_cnt <= word_cnt + 1'b1;
      if (state == RD_STILL) still_cnt <= still_cnt + 1'b1;
      else still_cnt <= '0;
    end
  end

  // ==================================================
  // chip output stage
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      chip_out.cs_n <= 1'b1;
      chip_out.oe   <= 1'b0;
      chip_out.data <= '0;
    end else begin
      chip_out.cs_n <= !word_pop;             // word shows the cycle after pop
      chip_out.oe   <= (next_state == RD_DATA); // tracks RD_DATA exactly
      if (word_pop) chip_out.data <= word_data;
    end
  end

endmodule

// File: read_path/beat_repacker.sv
`timescale 1ns/1ps
module beat_repacker
  import mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              beat_valid,
  input  logic [BEAT_W-1:0] beat_data,
  output logic              beat_pop,
  output logic              word_push,
  output logic [WORD_W-1:0] word_data,
  input  logic              word_full
);

  localparam int REST_W = WORD_W - BEAT_W;  // beat bits that spill over, 32

  logic [1:0]        phase;      // beat position within a triple
  logic [BEAT_W-1:0] part;       // beat 0, then upper half of beat 1
  logic              hold_valid;
  logic [WORD_W-1:0] hold_data;
  logic              room;

  assign word_push = hold_valid && !word_full;
  assign room      = !hold_valid || word_push;
  // first beat of a triple makes no word, so it never waits on room
  assign beat_pop  = beat_valid && (phase == 2'd0 || room);
  assign word_data = hold_data;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      phase      <= '0;
      hold_valid <= 1'b0;
    end else begin
      if (beat_pop) phase <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;
      if (beat_pop && phase != 2'd0) hold_valid <= 1'b1;
      else if (word_push) hold_valid <= 1'b0;
    end
  end

  // earliest beat lands in the low bits of each 192 bit triple
  always_ff @(posedge clk) begin
    if (beat_pop) begin
      case (phase)
        2'd0: part <= beat_data;
        2'd1: begin
          hold_data        <= {beat_data[REST_W-1:0], part};  // bits 95..0
          part[REST_W-1:0] <= beat_data[BEAT_W-1:BEAT_W-REST_W];
        end
        default: hold_data <= {beat_data, part[REST_W-1:0]};  // bits 191..96
      endcase
    end
  end

endmodule

// File: read_path/read_path.sv
`timescale 1ns/1ps
module read_path
  import mem_map_pkg::*;
  import chip_cmd_pkg::*;
#(
  parameter int BEAT_FIFO_LOG2 = 6,
  parameter int WORD_FIFO_LOG2 = 5
) (
  input  logic              clk,
  input  logic              reset,
  input  mem_beat_t         mem_beat,
  input  logic              word_pop,
  output logic              word_valid,
  output logic [WORD_W-1:0] word_data
);

  logic              beat_empty;
  logic [BEAT_W-1:0] beat_head;
  logic              beat_pop;
  logic              rp_push;
  logic [WORD_W-1:0] rp_word;
  logic              word_full;
  logic              word_empty;

  // beat buffer holds a whole transfer, memory never waits
  fifo_fwft #(.DATA_W(BEAT_W), .DEPTH_LOG2(BEAT_FIFO_LOG2)) u_beat_fifo (
    .clk(clk), .reset(reset),
    .push(mem_beat.valid), .data_in(mem_beat.data), .full(),
    .pop(beat_pop), .empty(beat_empty), .data_out(beat_head)
  );

  beat_repacker u_repacker (
    .clk(clk), .reset(reset),
    .beat_valid(!beat_empty), .beat_data(beat_head), .beat_pop(beat_pop),
    .word_push(rp_push), .word_data(rp_word), .word_full(word_full)
  );

  fifo_fwft #(.DATA_W(WORD_W), .DEPTH_LOG2(WORD_FIFO_LOG2)) u_word_fifo (
    .clk(clk), .reset(reset),
    .push(rp_push), .data_in(rp_word), .full(word_full),
    .pop(word_pop), .empty(word_empty), .data_out(word_data)
  );

  assign word_valid = !word_empty;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the chip read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  --top-module tb_chip_rd_top \
  -f chip_rd_top.f \
  -o sim_chip_rd
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_chip_rd
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
